//--- verilog.f
verilog/sp_pkg.sv
verilog/sp_ram.sv
verilog/sp_byte_bridge.sv
verilog/sp_mmio.sv
verilog/sp_top.sv
dv/sp_clk_gen.sv
dv/sp_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module sp_tb -f verilog.f -o sp_sim

# The log is searched below, so the run's own exit status is not used here.
./obj_dir/sp_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

//--- dv/sp_tb.sv
`timescale 1ns/1ps

module sp_tb import sp_pkg::*; ();

   localparam int TB_RAM_AW = 6;
   localparam int RAM_WORDS = 16;
   localparam int CLK_NS = 8;
   // Room for 200 accesses of 20 cycles each.
   localparam int WATCHDOG_NS = 200 * 20 * CLK_NS;
   localparam int ACK_LIMIT = 40;
   localparam addr_t EXT_BASE = {EXT_REGION, 24'h000000};
   localparam addr_t MMIO_BASE = {MMIO_REGION, 24'h000000};

   // One byte transfer as seen by the external device.
   typedef struct packed {
      ext_addr_t adr;
      logic      we;
      logic      sel;
      byte_t     dat;
   } xfer_t;

   logic       clk;
   logic       rst_n_i;
   addr_t      d_adr_i;
   data_t      d_dat_i;
   logic       d_we_i;
   sel_t       d_sel_i;
   logic       d_stb_i;
   logic       d_cyc_i;
   data_t      d_dat_o;
   logic       d_ack_o;
   ext_addr_t  ext_adr_o;
   byte_t      ext_dat_o;
   byte_t      ext_dat_i;
   logic       ext_we_o;
   logic       ext_sel_o;
   logic       ext_stb_o;
   logic       ext_ack_i;
   logic       ext_cyc_o;
   logic       led_green_o;
   logic       led_red_o;
   logic [4:0] sw_reset_o;
   rgb_t       led1_rgb_o;
   rgb_t       led2_rgb_o;
   rgb_t       led3_rgb_o;
   rgb_t       led4_rgb_o;
   logic [2:0] drive_activity_i;

   data_t       ram_ref [RAM_WORDS];
   byte_t       dev_mem [256];
   byte_t       dev_ref [256];
   xfer_t       xfers [$];
   logic [31:0] stim_rng = 32'd55;
   logic        led_green_ref;
   logic        led_red_ref;
   logic [4:0]  sw_reset_ref;
   rgb_t        rgb_ref [4];

   sp_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (.clk_o(clk));

   sp_top #(.RAM_AW(TB_RAM_AW)) u_sp_top (.*);

   task automatic end_run(input bit failed);
      if (!failed) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("Something failed");
         $fatal(1, "Simulation stopped at the first error");
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Mismatch at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      end_run(1'b1);
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0t ns: %s", $time, what);
      end_run(1'b1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else report_mismatch(name, exp, act);
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic data_t stim_rand();
      stim_rng = xorshift32(stim_rng);
      return stim_rng;
   endfunction

   // An odd multiplier gives every address its own byte.
   function automatic byte_t fill_byte(input int a);
      return byte_t'(a * 29 + 17);
   endfunction

   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input sel_t sel);
      data_t mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   // The lowest byte address lands in bits 31..24.
   function automatic data_t dev_word(input int word);
      return {dev_ref[8'(word * 4)], dev_ref[8'(word * 4 + 1)],
              dev_ref[8'(word * 4 + 2)], dev_ref[8'(word * 4 + 3)]};
   endfunction

   function automatic data_t mmio_expect(input logic [7:0] ofs);
      case (ofs)
         8'h00: return {30'd0, led_red_ref, led_green_ref};
         8'h04: return {27'd0, sw_reset_ref};
         8'h08: return {8'd0, rgb_ref[0]};
         8'h0c: return {8'd0, rgb_ref[1]};
         8'h10: return {8'd0, rgb_ref[2]};
         8'h14: return {8'd0, rgb_ref[3]};
         8'h18: return {29'd0, drive_activity_i};
         default: return '0;
      endcase
   endfunction

   task automatic bus_access(input addr_t adr, input logic we, input sel_t sel,
                             input data_t wdata, output data_t rdata, output int lat);
      @(posedge clk);
      #1;
      d_adr_i = adr;
      d_we_i = we;
      d_sel_i = sel;
      d_dat_i = wdata;
      d_cyc_i = 1'b1;
      d_stb_i = 1'b1;
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
         @(negedge clk);
         if (lat > ACK_LIMIT) begin
            report_failure("No acknowledge on d_ack_o within the access limit");
         end
      end while (!d_ack_o);
      rdata = d_dat_o;
      @(posedge clk);
      #1;
      d_cyc_i = 1'b0;
      d_stb_i = 1'b0;
      d_we_i = 1'b0;
   endtask

   task automatic single_cycle_access(input addr_t adr, input logic we, input sel_t sel,
                                      input data_t wdata, output data_t rdata);
      int lat;
      bus_access(adr, we, sel, wdata, rdata, lat);
      check_eq("d_ack_o latency in cycles", 1, lat);
   endtask

   task automatic check_xfers(input int base, input int word, input logic we,
                              input sel_t sel, input data_t wdata);
      xfer_t rec;
      check_eq("external transfers before d_ack_o", 4, xfers.size() - base);
      for (int n = 0; n < 4; n++) begin
         rec = xfers[base + n];
         check_eq("ext_adr_o", word * 4 + n, 32'(rec.adr));
         check_eq("ext_we_o", 32'(we), 32'(rec.we));
         if (we) begin
            check_eq("ext_dat_o", 32'(byte_t'(wdata >> (8 * (3 - n)))), 32'(rec.dat));
            check_eq("ext_sel_o", 32'(1'(sel >> (3 - n))), 32'(rec.sel));
         end
      end
   endtask

   task automatic bridge_access(input int word, input logic we, input sel_t sel,
                                input data_t wdata);
      data_t rdata;
      int    lat;
      int    base;
      base = xfers.size();
      bus_access(EXT_BASE + addr_t'(word * 4), we, sel, wdata, rdata, lat);
      check_xfers(base, word, we, sel, wdata);
      if (!we) begin
         check_eq("d_dat_o", dev_word(word), rdata);
      end else begin
         for (int n = 0; n < 4; n++) begin
            if (1'(sel >> (3 - n))) begin
               dev_ref[8'(word * 4 + n)] = byte_t'(wdata >> (8 * (3 - n)));
            end
         end
         for (int a = 0; a < 256; a++) begin
            check_eq($sformatf("device byte %0d", a), 32'(dev_ref[8'(a)]), 32'(dev_mem[8'(a)]));
         end
      end
   endtask

   task automatic check_mmio_outputs();
      check_eq("led_green_o", 32'(led_green_ref), 32'(led_green_o));
      check_eq("led_red_o", 32'(led_red_ref), 32'(led_red_o));
      check_eq("sw_reset_o", 32'(sw_reset_ref), 32'(sw_reset_o));
      check_eq("led1_rgb_o", 32'(rgb_ref[0]), 32'(led1_rgb_o));
      check_eq("led2_rgb_o", 32'(rgb_ref[1]), 32'(led2_rgb_o));
      check_eq("led3_rgb_o", 32'(rgb_ref[2]), 32'(led3_rgb_o));
      check_eq("led4_rgb_o", 32'(rgb_ref[3]), 32'(led4_rgb_o));
   endtask

   task automatic mmio_access(input logic [7:0] ofs, input logic we, input sel_t sel,
                              input data_t wdata);
      data_t rdata;
      data_t merged;
      merged = merge_bytes(mmio_expect(ofs), wdata, sel);
      single_cycle_access(MMIO_BASE + addr_t'(ofs), we, sel, wdata, rdata);
      if (!we) begin
         check_eq("d_dat_o", mmio_expect(ofs), rdata);
      end else begin
         case (ofs)
            8'h00: begin
               led_green_ref = merged[0];
               led_red_ref = merged[1];
            end
            8'h04: sw_reset_ref = merged[4:0];
            8'h08: rgb_ref[0] = merged[23:0];
            8'h0c: rgb_ref[1] = merged[23:0];
            8'h10: rgb_ref[2] = merged[23:0];
            8'h14: rgb_ref[3] = merged[23:0];
            default: ;
         endcase
      end
      check_mmio_outputs();
   endtask

   assert property (@(posedge clk) disable iff (!rst_n_i) d_ack_o |=> !d_ack_o)
      else report_mismatch("d_ack_o one cycle later", 0, 1);
   // Back-pressure holds the byte transfer in place.
   assert property (@(posedge clk) disable iff (!rst_n_i)
                    ext_stb_o && !ext_ack_i |=> ext_stb_o && $stable(ext_adr_o))
      else report_failure("ext_stb_o dropped or ext_adr_o moved while waiting for ext_ack_i");
   assert property (@(posedge clk) disable iff (!rst_n_i)
                    d_ack_o && d_adr_i[31:24] == EXT_REGION
                    |-> $past(ext_stb_o && ext_ack_i && ext_adr_o[1:0] == 2'b11))
      else report_mismatch("d_ack_o before the fourth ext_ack_i", 0, 1);
   // The word ack follows the last byte ack by one cycle.
   assert property (@(posedge clk) disable iff (!rst_n_i)
                    ext_stb_o && ext_ack_i && ext_adr_o[1:0] == 2'b11 |=> d_ack_o)
      else report_mismatch("d_ack_o after the fourth ext_ack_i", 1, 0);

   // External byte device that answers after 0 to 3 idle cycles.
   initial begin : ext_device
      logic [31:0] dev_rng;
      logic        ack_next;
      byte_t       dat_next;
      logic        armed;
      int          wait_left;
      dev_rng = 32'd55;
      armed = 1'b0;
      wait_left = 0;
      ext_ack_i = 1'b0;
      ext_dat_i = '0;
      for (int a = 0; a < 256; a++) begin
         dev_mem[8'(a)] = fill_byte(a);
      end
      forever begin
         @(posedge clk);
         ack_next = 1'b0;
         dat_next = '0;
         if (ext_stb_o && ext_ack_i) begin
            xfers.push_back('{ext_adr_o, ext_we_o, ext_sel_o, ext_dat_o});
            if (ext_we_o && ext_sel_o) begin
               dev_mem[ext_adr_o[7:0]] = ext_dat_o;
            end
            armed = 1'b0;
         end else if (ext_stb_o) begin
            if (!armed) begin
               dev_rng = xorshift32(dev_rng);
               wait_left = int'(dev_rng[1:0]);
               armed = 1'b1;
            end
            if (wait_left == 0) begin
               ack_next = 1'b1;
               dat_next = dev_mem[ext_adr_o[7:0]];
            end else begin
               wait_left--;
            end
         end else begin
            armed = 1'b0;
         end
         #1;
         ext_ack_i = ack_next;
         ext_dat_i = dat_next;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      report_failure("Watchdog expired before the tests completed");
   end

   initial begin : main
      logic [31:0] r;
      data_t       rdata;
      rst_n_i = 1'b0;
      d_adr_i = '0;
      d_dat_i = '0;
      d_we_i = 1'b0;
      d_sel_i = '0;
      d_stb_i = 1'b0;
      d_cyc_i = 1'b0;
      drive_activity_i = '0;
      led_green_ref = 1'b0;
      led_red_ref = 1'b0;
      sw_reset_ref = '0;
      for (int i = 0; i < 4; i++) begin
         rgb_ref[i] = '0;
      end
      for (int a = 0; a < 256; a++) begin
         dev_ref[8'(a)] = fill_byte(a);
      end
      repeat (2) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      @(negedge clk);
      check_eq("d_ack_o", 0, 32'(d_ack_o));
      check_eq("ext_stb_o", 0, 32'(ext_stb_o));
      check_eq("ext_cyc_o", 0, 32'(ext_cyc_o));
      check_mmio_outputs();

      // Unmapped space answers with zero data.
      single_cycle_access(32'h9000_0000, 1'b0, 4'hf, '0, rdata);
      check_eq("d_dat_o", 0, rdata);
      single_cycle_access(32'hc000_1234, 1'b1, 4'hf, 32'hdead_beef, rdata);
      single_cycle_access(32'h8100_0010, 1'b0, 4'hf, '0, rdata);
      check_eq("d_dat_o", 0, rdata);

      for (int i = 0; i < RAM_WORDS; i++) begin
         ram_ref[4'(i)] = stim_rand();
         single_cycle_access(addr_t'(i * 4), 1'b1, 4'hf, ram_ref[4'(i)], rdata);
      end
      for (int i = 0; i < 24; i++) begin
         r = stim_rand();
         rdata = stim_rand();
         ram_ref[r[3:0]] = merge_bytes(ram_ref[r[3:0]], rdata, r[7:4]);
         single_cycle_access(addr_t'({r[3:0], 2'b00}), 1'b1, r[7:4], rdata, rdata);
      end
      for (int i = 0; i < RAM_WORDS; i++) begin
         single_cycle_access(addr_t'(i * 4), 1'b0, 4'hf, '0, rdata);
         check_eq("d_dat_o", ram_ref[4'(i)], rdata);
      end

      for (int i = 0; i < 4; i++) begin
         bridge_access(int'(stim_rand() & 32'h3f), 1'b0, 4'hf, '0);
      end
      for (int i = 0; i < 6; i++) begin
         r = stim_rand();
         bridge_access(int'(r[5:0]), 1'b1, r[11:8], stim_rand());
         bridge_access(int'(r[5:0]), 1'b0, 4'hf, '0);
      end

      for (int k = 0; k < 3; k++) begin
         for (int j = 0; j < 6; j++) begin
            r = stim_rand();
            mmio_access(8'(j * 4), 1'b1, r[3:0], stim_rand());
            mmio_access(8'(j * 4), 1'b0, 4'hf, '0);
         end
      end
      mmio_access(8'h1c, 1'b0, 4'hf, '0);
      @(posedge clk);
      #1;
      drive_activity_i = 3'b101;
      repeat (3) @(posedge clk);
      mmio_access(8'h18, 1'b1, 4'hf, 32'hffff_ffff);
      mmio_access(8'h18, 1'b0, 4'hf, '0);
      @(posedge clk);
      #1;
      drive_activity_i = 3'b010;
      repeat (3) @(posedge clk);
      mmio_access(8'h18, 1'b0, 4'hf, '0);

      end_run(1'b0);
   end

endmodule

//--- dv/sp_clk_gen.sv
`timescale 1ns/1ps

module sp_clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk_o
);

   // The first rising edge comes after half a period.
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

//--- verilog/sp_top.sv
`timescale 1ns/1ps

module sp_top import sp_pkg::*; #(
   parameter int RAM_AW = 10
) (
   input  logic       clk,
   input  logic       rst_n_i,
   input  addr_t      d_adr_i,
   input  data_t      d_dat_i,
   input  logic       d_we_i,
   input  sel_t       d_sel_i,
   input  logic       d_stb_i,
   input  logic       d_cyc_i,
   output data_t      d_dat_o,
   output logic       d_ack_o,
   output ext_addr_t  ext_adr_o,
   output byte_t      ext_dat_o,
   input  byte_t      ext_dat_i,
   output logic       ext_we_o,
   output logic       ext_sel_o,
   output logic       ext_stb_o,
   input  logic       ext_ack_i,
   output logic       ext_cyc_o,
   output logic       led_green_o,
   output logic       led_red_o,
   output logic [4:0] sw_reset_o,
   output rgb_t       led1_rgb_o,
   output rgb_t       led2_rgb_o,
   output rgb_t       led3_rgb_o,
   output rgb_t       led4_rgb_o,
   input  logic [2:0] drive_activity_i
);

   logic  req;
   logic  ram_hit;
   logic  ext_hit;
   logic  mmio_hit;
   logic  unmap_hit;
   logic  ram_stb;
   logic  ext_stb;
   logic  mmio_stb;
   logic  unmap_stb;
   logic  ram_ack;
   logic  ext_ack;
   logic  mmio_ack;
   logic  unmap_ack;
   data_t ram_dat;
   data_t ext_dat;
   data_t mmio_dat;

   assign req = d_cyc_i && d_stb_i;

   // RAM takes the whole lower half.
   assign ram_hit = !d_adr_i[31];
   assign ext_hit = d_adr_i[31:24] == EXT_REGION;
   assign mmio_hit = d_adr_i[31:24] == MMIO_REGION;
   assign unmap_hit = !(ram_hit || ext_hit || mmio_hit);

   assign ram_stb = req && ram_hit;
   assign ext_stb = req && ext_hit;
   assign mmio_stb = req && mmio_hit;
   assign unmap_stb = req && unmap_hit;

   // Unmapped accesses get a single-cycle ack so the master never hangs.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         unmap_ack <= 1'b0;
      end else begin
         unmap_ack <= unmap_stb && !unmap_ack;
      end
   end

   assign d_ack_o = ram_ack | ext_ack | mmio_ack | unmap_ack;

   always_comb begin
      if (ram_hit) begin
         d_dat_o = ram_dat;
      end else if (ext_hit) begin
         d_dat_o = ext_dat;
      end else if (mmio_hit) begin
         d_dat_o = mmio_dat;
      end else begin
         d_dat_o = '0;
      end
   end

   sp_ram #(
      .RAM_AW (RAM_AW)
   ) u_ram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .adr_i   (d_adr_i[RAM_AW+1:2]),
      .stb_i   (ram_stb),
      .we_i    (d_we_i),
      .sel_i   (d_sel_i),
      .dat_i   (d_dat_i),
      .ack_o   (ram_ack),
      .dat_o   (ram_dat)
   );

   sp_byte_bridge u_bridge (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .adr_i     (d_adr_i[23:2]),
      .stb_i     (ext_stb),
      .cyc_i     (d_cyc_i && ext_hit),
      .we_i      (d_we_i),
      .sel_i     (d_sel_i),
      .dat_i     (d_dat_i),
      .ext_dat_i (ext_dat_i),
      .ext_ack_i (ext_ack_i),
      .ack_o     (ext_ack),
      .dat_o     (ext_dat),
      .ext_adr_o (ext_adr_o),
      .ext_dat_o (ext_dat_o),
      .ext_we_o  (ext_we_o),
      .ext_sel_o (ext_sel_o),
      .ext_stb_o (ext_stb_o),
      .ext_cyc_o (ext_cyc_o)
   );

   sp_mmio u_mmio (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .adr_i            (d_adr_i[7:0]),
      .stb_i            (mmio_stb),
      .we_i             (d_we_i),
      .sel_i            (d_sel_i),
      .dat_i            (d_dat_i),
      .drive_activity_i (drive_activity_i),
      .ack_o            (mmio_ack),
      .dat_o            (mmio_dat),
      .led_green_o      (led_green_o),
      .led_red_o        (led_red_o),
      .sw_reset_o       (sw_reset_o),
      .led1_rgb_o       (led1_rgb_o),
      .led2_rgb_o       (led2_rgb_o),
      .led3_rgb_o       (led3_rgb_o),
      .led4_rgb_o       (led4_rgb_o)
   );

endmodule

//--- verilog/sp_mmio.sv
`timescale 1ns/1ps

module sp_mmio import sp_pkg::*; (
   input  logic       clk,
   input  logic       rst_n_i,
   input  logic [7:0] adr_i,
   input  logic       stb_i,
   input  logic       we_i,
   input  sel_t       sel_i,
   input  data_t      dat_i,
   input  logic [2:0] drive_activity_i,
   output logic       ack_o,
   output data_t      dat_o,
   output logic       led_green_o,
   output logic       led_red_o,
   output logic [4:0] sw_reset_o,
   output rgb_t       led1_rgb_o,
   output rgb_t       led2_rgb_o,
   output rgb_t       led3_rgb_o,
   output rgb_t       led4_rgb_o
);

   localparam logic [7:0] OFS_LED = 8'h00;
   localparam logic [7:0] OFS_RESET = 8'h04;
   localparam logic [7:0] OFS_RGB1 = 8'h08;
   localparam logic [7:0] OFS_RGB2 = 8'h0c;
   localparam logic [7:0] OFS_RGB3 = 8'h10;
   localparam logic [7:0] OFS_RGB4 = 8'h14;
   localparam logic [7:0] OFS_STATUS = 8'h18;

   logic       access;
   logic       wr_en;
   logic [2:0] activity_meta;
   logic [2:0] activity_sync;
   data_t      rd_data;
   data_t      wr_data;

   assign access = stb_i && !ack_o;
   assign wr_en = access && we_i;

   // Current contents of the addressed register.
   always_comb begin
      rd_data = '0;
      case (adr_i)
         OFS_LED: rd_data[1:0] = {led_red_o, led_green_o};
         OFS_RESET: rd_data[4:0] = sw_reset_o;
         OFS_RGB1: rd_data[23:0] = led1_rgb_o;
         OFS_RGB2: rd_data[23:0] = led2_rgb_o;
         OFS_RGB3: rd_data[23:0] = led3_rgb_o;
         OFS_RGB4: rd_data[23:0] = led4_rgb_o;
         OFS_STATUS: rd_data[2:0] = activity_sync;
         default: rd_data = '0;
      endcase
   end

   // Lanes without a select keep the register's value.
   always_comb begin
      wr_data = rd_data;
      for (int i = 0; i < 4; i++) begin
         if (sel_i[i]) begin
            wr_data[8*i +: 8] = dat_i[8*i +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         dat_o <= rd_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         led_green_o <= 1'b0;
         led_red_o <= 1'b0;
         sw_reset_o <= '0;
         led1_rgb_o <= '0;
         led2_rgb_o <= '0;
         led3_rgb_o <= '0;
         led4_rgb_o <= '0;
      end else if (wr_en) begin
         case (adr_i)
            OFS_LED: begin
               led_green_o <= wr_data[0];
               led_red_o <= wr_data[1];
            end
            OFS_RESET: sw_reset_o <= wr_data[4:0];
            OFS_RGB1: led1_rgb_o <= wr_data[23:0];
            OFS_RGB2: led2_rgb_o <= wr_data[23:0];
            OFS_RGB3: led3_rgb_o <= wr_data[23:0];
            OFS_RGB4: led4_rgb_o <= wr_data[23:0];
            default: ;
         endcase
      end
   end

   // Drive activity comes from another clock domain.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         activity_meta <= '0;
         activity_sync <= '0;
      end else begin
         activity_meta <= drive_activity_i;
         activity_sync <= activity_meta;
      end
   end

endmodule

//--- verilog/sp_byte_bridge.sv
`timescale 1ns/1ps

module sp_byte_bridge import sp_pkg::*; (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic [21:0] adr_i,
   input  logic        stb_i,
   input  logic        cyc_i,
   input  logic        we_i,
   input  sel_t        sel_i,
   input  data_t       dat_i,
   input  byte_t       ext_dat_i,
   input  logic        ext_ack_i,
   output logic        ack_o,
   output data_t       dat_o,
   output ext_addr_t   ext_adr_o,
   output byte_t       ext_dat_o,
   output logic        ext_we_o,
   output logic        ext_sel_o,
   output logic        ext_stb_o,
   output logic        ext_cyc_o
);

   logic [1:0] subaddr;
   logic [1:0] lane;
   logic       active;
   logic       byte_done;
   data_t      shift_q;

   // Byte transfers run until the word ack goes out.
   assign active = cyc_i && stb_i && !ack_o;
   assign byte_done = active && ext_ack_i;

   // Sub-address 0 is the top byte, selected by sel bit 3.
   assign lane = ~subaddr;

   assign ext_cyc_o = cyc_i;
   assign ext_stb_o = active;
   assign ext_we_o = we_i;
   assign ext_adr_o = {adr_i, subaddr};
   assign ext_sel_o = sel_i[lane];
   assign ext_dat_o = dat_i[{lane, 3'b000} +: 8];

   assign dat_o = shift_q;

   // The counter steps on each byte ack.
   // Ack follows the fourth byte, then everything clears.
   always_ff @(posedge clk) begin
      if (!rst_n_i || !cyc_i || !stb_i || ack_o) begin
         subaddr <= 2'b00;
         ack_o <= 1'b0;
      end else if (ext_ack_i) begin
         subaddr <= subaddr + 2'd1;
         if (subaddr == 2'b11) begin
            ack_o <= 1'b1;
         end
      end
   end

   // Bytes enter at the bottom, so the first one ends up in bits 31..24.
   always_ff @(posedge clk) begin
      if (byte_done) begin
         shift_q <= {shift_q[23:0], ext_dat_i};
      end
   end

endmodule

//--- verilog/sp_ram.sv
`timescale 1ns/1ps

module sp_ram import sp_pkg::*; #(
   parameter int RAM_AW = 10
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic [RAM_AW-1:0] adr_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  sel_t              sel_i,
   input  data_t             dat_i,
   output logic              ack_o,
   output data_t             dat_o
);

   localparam int DEPTH = 1 << RAM_AW;

   data_t mem [DEPTH];

   logic access;

   // A strobe is served once, in the cycle before its ack.
   assign access = stb_i && !ack_o;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   // Sel bit i covers data bits 8*i+7 down to 8*i.
   always_ff @(posedge clk) begin
      if (access && we_i) begin
         for (int i = 0; i < 4; i++) begin
            if (sel_i[i]) begin
               mem[adr_i][8*i +: 8] <= dat_i[8*i +: 8];
            end
         end
      end
   end

   // Read data lines up with the ack.
   always_ff @(posedge clk) begin
      if (access && !we_i) begin
         dat_o <= mem[adr_i];
      end
   end

endmodule

//--- verilog/sp_pkg.sv
package sp_pkg;

   // Data bus of the service processor.
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // Sel bit 3 selects byte lane 0, which is data bits 31..24.
   typedef logic [3:0] sel_t;

   // External 8-bit bus.
   typedef logic [7:0] byte_t;
   typedef logic [23:0] ext_addr_t;

   // One RGB LED colour.
   typedef logic [23:0] rgb_t;

   // Top address byte of the bridge region.
   localparam logic [7:0] EXT_REGION = 8'h80;

   // Top address byte of the register block.
   localparam logic [7:0] MMIO_REGION = 8'hff;

endpackage
